//--- build.f
+incdir+hw
hw/st_align_pkg.sv
hw/st_cfg_regs.sv
hw/st_elem_compact.sv
hw/st_byte_rot.sv
hw/st_align_buffer.sv
hw/st_align_top.sv
test/tb_st_align.sv

//--- hw/st_align_buffer.sv
/*
 * store align buffer
 *   places packed bytes at the fill pointer
 *   merges them with held bytes into 8-lane memory beats
 *   keeps the overflow bytes at lane 0 for the next beat
 *   sends a residual beat after the last input
 */

`timescale 1ns/1ps

`include "st_align_cfg.svh"

module st_align_buffer (
  input  logic                      align_clk,
  input  logic                      cpurst_b,
  input  logic                      flush,
  input  st_align_pkg::st_desc_t    desc,
  input  logic                      seq_active,
  input  logic                      seq_start,
  input  logic                      in_vld,
  input  st_align_pkg::pack_beat_t  pack_beat,
  output logic                      in_ack,
  output logic                      in_take,
  input  logic                      mem_ready,
  output logic                      mem_vld,
  output st_align_pkg::mem_beat_t   mem_beat,
  output logic                      seq_done
);

  localparam logic [`ST_CNTW-1:0] LANES = `ST_BYTEW;

  // lanes below n set, n from 0 to 8
  function automatic logic [`ST_BYTEW-1:0] lane_mask(input logic [`ST_CNTW-1:0] n);
    logic [`ST_BYTEW-1:0] m;
    for (int i = 0; i < `ST_BYTEW; i++)
    begin
      m[i] = (i < n);
    end
    return m;
  endfunction

  // byte enable to bit mask
  function automatic logic [`ST_DATAW-1:0] byte_ext(input logic [`ST_BYTEW-1:0] m);
    logic [`ST_DATAW-1:0] e;
    for (int i = 0; i < `ST_BYTEW; i++)
    begin
      e[i*8 +: 8] = {8{m[i]}};
    end
    return e;
  endfunction

  // held state
  logic [`ST_DATAW-1:0] hold_data;
  logic [`ST_CNTW-1:0]  hold_cnt;
  logic [2:0]           ptr_q;
  logic                 pend_last;

  // pointer view for this cycle
  logic [2:0]           ptr;
  logic [2:0]           lo;
  logic [`ST_CNTW-1:0]  cnt;
  logic [`ST_CNTW-1:0]  sum;
  logic [`ST_CNTW-1:0]  fit_n;
  logic [`ST_CNTW-1:0]  end_n;
  logic [`ST_CNTW-1:0]  ovf_n;

  // lane masks
  logic [`ST_BYTEW-1:0] hold_mask;
  logic [`ST_BYTEW-1:0] fit_mask;
  logic [`ST_BYTEW-1:0] ovf_mask;
  logic [`ST_BYTEW-1:0] be_cur;

  // data paths
  logic [`ST_DATAW-1:0] hold_vis;
  logic [`ST_DATAW-1:0] fit_data;
  logic [`ST_DATAW-1:0] ovf_data;
  logic [`ST_DATAW-1:0] placed_fit;
  logic [`ST_DATAW-1:0] placed_ovf;

  // decisions
  logic                 full;
  logic                 fits;
  logic                 in_go;
  logic                 need_beat;
  logic                 consume;

  // ==============================
  // pointer and counts
  // ==============================
  // first beat starts at the descriptor lane with nothing held
  assign ptr = seq_start ? desc.rot : ptr_q;
  assign cnt = seq_start ? '0 : hold_cnt;

  // lowest held lane, lanes below stay disabled
  assign lo  = ptr - cnt[2:0];

  assign sum   = {1'b0, ptr} + pack_beat.nbytes;
  assign full  = (sum >= LANES);
  assign fits  = (sum <= LANES);

  // bytes that land in the current beat
  assign fit_n = full ? (LANES - {1'b0, ptr}) : pack_beat.nbytes;
  assign end_n = full ? LANES : sum;
  // overflow count, only meaningful when !fits
  assign ovf_n = sum - LANES;

  // ==============================
  // lane masks and placement
  // ==============================
  assign hold_mask = lane_mask({1'b0, ptr}) & ~lane_mask({1'b0, lo});
  assign fit_mask  = lane_mask(fit_n);
  assign ovf_mask  = lane_mask(pack_beat.nbytes) & ~fit_mask;
  assign be_cur    = lane_mask(end_n) & ~lane_mask({1'b0, lo});

  assign hold_vis  = hold_data & byte_ext(hold_mask);
  assign fit_data  = pack_beat.data & byte_ext(fit_mask);
  assign ovf_data  = pack_beat.data & byte_ext(ovf_mask);

  // fitting bytes go up to the fill pointer
  st_byte_rot x_place_rot (
    .data_in  (fit_data  ),
    .lane_sel (ptr       ),
    .data_out (placed_fit)
  );

  // overflow bytes wrap down to lane 0
  st_byte_rot x_left_rot (
    .data_in  (ovf_data  ),
    .lane_sel (ptr       ),
    .data_out (placed_ovf)
  );

  // ==============================
  // handshake
  // ==============================
  // no new input while a residual beat is owed
  assign in_go     = in_vld & seq_active & ~pend_last;

  // a beat is due on a full lane set or on the last input
  assign need_beat = in_go & (full | pack_beat.last);

  // take only if no beat is due or memory takes it now
  assign in_ack    = in_go & (~need_beat | mem_ready);
  assign in_take   = in_vld & in_ack;

  assign mem_vld   = pend_last | need_beat;
  assign consume   = mem_vld & mem_ready;

  always_comb
  begin
    if (pend_last)
    begin
      // residual beat alone, held bytes start at lane 0
      mem_beat.data = hold_vis;
      mem_beat.be   = hold_mask;
      mem_beat.last = 1'b1;
    end
    else
    begin
      mem_beat.data = hold_vis | placed_fit;
      mem_beat.be   = be_cur;
      mem_beat.last = pack_beat.last & fits;
    end
  end

  assign seq_done = consume & mem_beat.last;

  // ==============================
  // held state update
  // ==============================
  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      hold_cnt  <= '0;
      ptr_q     <= '0;
      pend_last <= 1'b0;
    end
    else if (flush)
    begin
      hold_cnt  <= '0;
      ptr_q     <= '0;
      pend_last <= 1'b0;
    end
    else if (pend_last & mem_ready)
    begin
      // residual gone, sequence over
      hold_cnt  <= '0;
      ptr_q     <= '0;
      pend_last <= 1'b0;
    end
    else if (in_take)
    begin
      if (need_beat & ~fits)
      begin
        // overflow kept, residual owed if this was the last input
        hold_cnt  <= ovf_n;
        ptr_q     <= ovf_n[2:0];
        pend_last <= pack_beat.last;
      end
      else if (need_beat)
      begin
        hold_cnt  <= '0;
        ptr_q     <= '0;
      end
      else
      begin
        // still short of a beat
        hold_cnt  <= cnt + pack_beat.nbytes;
        ptr_q     <= sum[2:0];
      end
    end
  end

  // held bytes, lanes outside hold_mask are don't care
  always_ff @(posedge align_clk)
  begin
    if (in_take)
      hold_data <= need_beat ? placed_ovf : (hold_vis | placed_fit);
  end

  a_hold_max: assert property (@(posedge align_clk) disable iff (!cpurst_b)
    hold_cnt <= `ST_HOLDMAX)
    else $error("held byte count above limit");

  // a stalled beat keeps its content until memory takes it
  a_beat_stable: assert property (@(posedge align_clk) disable iff (!cpurst_b)
    (mem_vld && !mem_ready && !flush) |=> (mem_vld && $stable(mem_beat)))
    else $error("mem_beat changed while stalled");

  // nothing held once a sequence has ended or was flushed
  a_idle_empty: assert property (@(posedge align_clk) disable iff (!cpurst_b)
    !seq_active |-> (hold_cnt == '0 && !pend_last))
    else $error("bytes held outside a sequence");

endmodule

//--- hw/st_align_cfg.svh
/*
 * store align stage widths
 *   data word width, byte lane count, byte count width
 *   deepest leftover held between memory beats
 */

`ifndef ST_ALIGN_CFG_SVH
`define ST_ALIGN_CFG_SVH

// one register or memory word
`define ST_DATAW 64

// byte lanes in a word
`define ST_BYTEW 8

// byte counts run 0 to 8
`define ST_CNTW 4

// leftover bytes kept between beats
`define ST_HOLDMAX 7

`endif

//--- hw/st_align_pkg.sv
/*
 * shared types of the store align stage
 *   element size encoding, sequence descriptor
 *   register, packed and memory beat structs
 *   lane view union of a data word
 */

`include "st_align_cfg.svh"

package st_align_pkg;

  // element width encoding, same for sew and mem_size
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HALF  = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } size_e;

  // one store sequence
  typedef struct packed {
    logic [2:0] rot;
    size_e      sew;
    size_e      mem_size;
  } st_desc_t;

  // beat as read from the register file
  typedef struct packed {
    logic [`ST_DATAW-1:0] data;
    logic                 last;
  } reg_beat_t;

  // beat after narrowing, valid bytes packed low
  typedef struct packed {
    logic [`ST_DATAW-1:0] data;
    logic [`ST_CNTW-1:0]  nbytes;
    logic                 last;
  } pack_beat_t;

  // aligned beat toward memory
  typedef struct packed {
    logic [`ST_DATAW-1:0] data;
    logic [`ST_BYTEW-1:0] be;
    logic                 last;
  } mem_beat_t;

  // one word seen as bytes, halfwords or words
  typedef union packed {
    logic [`ST_BYTEW-1:0][7:0]    b;
    logic [`ST_BYTEW/2-1:0][15:0] h;
    logic [`ST_BYTEW/4-1:0][31:0] w;
  } lane_word_u;

endpackage

//--- hw/st_align_top.sv
/*
 * store align stage top
 *   configuration block, element compactor, align buffer
 */

`timescale 1ns/1ps

module st_align_top (
  input  logic                     align_clk,
  input  logic                     cpurst_b,
  input  logic                     cfg_wr,
  input  st_align_pkg::st_desc_t   cfg_desc,
  input  logic                     flush,
  input  logic                     in_vld,
  input  st_align_pkg::reg_beat_t  in_beat,
  output logic                     in_ack,
  input  logic                     mem_ready,
  output logic                     mem_vld,
  output st_align_pkg::mem_beat_t  mem_beat
);

  st_align_pkg::st_desc_t    desc;
  st_align_pkg::pack_beat_t  pack_beat;
  logic                      seq_active;
  logic                      seq_start;
  logic                      seq_done;
  logic                      in_take;

  // descriptor and sequence state
  st_cfg_regs x_st_cfg_regs (
    .align_clk  (align_clk ),
    .cpurst_b   (cpurst_b  ),
    .cfg_wr     (cfg_wr    ),
    .cfg_desc   (cfg_desc  ),
    .flush      (flush     ),
    .seq_done   (seq_done  ),
    .in_take    (in_take   ),
    .desc       (desc      ),
    .seq_active (seq_active),
    .seq_start  (seq_start )
  );

  // narrowing, same cycle
  st_elem_compact x_st_elem_compact (
    .in_beat   (in_beat  ),
    .desc      (desc     ),
    .pack_beat (pack_beat)
  );

  st_align_buffer x_st_align_buffer (
    .align_clk  (align_clk ),
    .cpurst_b   (cpurst_b  ),
    .flush      (flush     ),
    .desc       (desc      ),
    .seq_active (seq_active),
    .seq_start  (seq_start ),
    .in_vld     (in_vld    ),
    .pack_beat  (pack_beat ),
    .in_ack     (in_ack    ),
    .in_take    (in_take   ),
    .mem_ready  (mem_ready ),
    .mem_vld    (mem_vld   ),
    .mem_beat   (mem_beat  ),
    .seq_done   (seq_done  )
  );

endmodule

//--- hw/st_byte_rot.sv
/*
 * byte lane rotator
 *   rotates a word upward by 0 to 7 byte lanes
 *   three stages of 1, 2 and 4 lanes
 */

`timescale 1ns/1ps

`include "st_align_cfg.svh"

module st_byte_rot (
  input  logic [`ST_DATAW-1:0] data_in,
  input  logic [2:0]           lane_sel,
  output logic [`ST_DATAW-1:0] data_out
);

  logic [`ST_DATAW-1:0] stage1;
  logic [`ST_DATAW-1:0] stage2;

  // one lane, top byte wraps to lane 0
  assign stage1 = lane_sel[0] ? {data_in[`ST_DATAW-9:0], data_in[`ST_DATAW-1 -: 8]}
                              : data_in;

  // two lanes
  assign stage2 = lane_sel[1] ? {stage1[`ST_DATAW-17:0], stage1[`ST_DATAW-1 -: 16]}
                              : stage1;

  // four lanes
  assign data_out = lane_sel[2] ? {stage2[`ST_DATAW-33:0], stage2[`ST_DATAW-1 -: 32]}
                                : stage2;

endmodule

//--- hw/st_cfg_regs.sv
/*
 * store sequence configuration
 *   descriptor register loaded by a one-cycle strobe
 *   sequence active flag and first beat tracking
 */

`timescale 1ns/1ps

module st_cfg_regs (
  input  logic                    align_clk,
  input  logic                    cpurst_b,
  input  logic                    cfg_wr,
  input  st_align_pkg::st_desc_t  cfg_desc,
  input  logic                    flush,
  input  logic                    seq_done,
  input  logic                    in_take,
  output st_align_pkg::st_desc_t  desc,
  output logic                    seq_active,
  output logic                    seq_start
);

  // set by the strobe, gone after the first accepted input
  logic first_beat;

  // ==============================
  // descriptor
  // ==============================
  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      desc <= '0;
    else if (cfg_wr)
      desc <= cfg_desc;
  end

  // ==============================
  // sequence state
  // ==============================
  // flush wins over a new strobe
  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      seq_active <= 1'b0;
    else if (flush)
      seq_active <= 1'b0;
    else if (cfg_wr)
      seq_active <= 1'b1;
    else if (seq_done)
      seq_active <= 1'b0;
  end

  always_ff @(posedge align_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      first_beat <= 1'b0;
    else if (flush)
      first_beat <= 1'b0;
    else if (cfg_wr)
      first_beat <= 1'b1;
    else if (in_take)
      first_beat <= 1'b0;
  end

  // fill pointer comes from desc.rot while this is high
  assign seq_start = seq_active & first_beat;

  // new descriptor only between sequences
  a_cfg_idle: assert property (@(posedge align_clk) disable iff (!cpurst_b)
    cfg_wr |-> !seq_active)
    else $error("cfg_wr during an active sequence");

  // widening stores are not handled by the compactor
  a_no_widen: assert property (@(posedge align_clk) disable iff (!cpurst_b)
    seq_active |-> (desc.mem_size <= desc.sew))
    else $error("mem_size wider than sew");

endmodule

//--- hw/st_elem_compact.sv
/*
 * element compactor
 *   keeps the low part of each register element
 *   packs the kept bytes into the low lanes
 *   reports the valid byte count of the beat
 */

`timescale 1ns/1ps

`include "st_align_cfg.svh"

module st_elem_compact (
  input  st_align_pkg::reg_beat_t   in_beat,
  input  st_align_pkg::st_desc_t    desc,
  output st_align_pkg::pack_beat_t  pack_beat
);

  // register word and packed result in lane view
  st_align_pkg::lane_word_u src;
  st_align_pkg::lane_word_u dst;
  logic [`ST_CNTW-1:0]      nbytes;

  assign src = in_beat.data;

  always_comb
  begin
    // unused upper lanes stay zero
    dst    = '0;
    nbytes = `ST_CNTW'(`ST_BYTEW);
    case ({desc.mem_size, desc.sew})
      // low byte of each halfword
      {st_align_pkg::BYTE, st_align_pkg::HALF}:
      begin
        for (int i = 0; i < `ST_BYTEW/2; i++)
        begin
          dst.b[i] = src.h[i][7:0];
        end
        nbytes = `ST_CNTW'(`ST_BYTEW/2);
      end
      // low byte of each word
      {st_align_pkg::BYTE, st_align_pkg::WORD}:
      begin
        for (int i = 0; i < `ST_BYTEW/4; i++)
        begin
          dst.b[i] = src.w[i][7:0];
        end
        nbytes = `ST_CNTW'(`ST_BYTEW/4);
      end
      // low halfword of each word
      {st_align_pkg::HALF, st_align_pkg::WORD}:
      begin
        for (int i = 0; i < `ST_BYTEW/4; i++)
        begin
          dst.h[i] = src.w[i][15:0];
        end
        nbytes = `ST_CNTW'(`ST_BYTEW/2);
      end
      // equal sizes pass through whole
      default:
      begin
        dst = src;
      end
    endcase
  end

  assign pack_beat.data   = dst;
  assign pack_beat.nbytes = nbytes;
  assign pack_beat.last   = in_beat.last;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the store align testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_st_align -Mdir obj_dir -o sim_st_align
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_st_align > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL: pass message not found in sim.log"
exit 1

//--- test/tb_st_align.sv
/*
 * testbench of the store align stage
 *   reset check with no sequence configured
 *   random sequences from a fixed seed, some flushed midway
 *   byte stream model cut into 8-lane memory beats
 *   back-pressure checks and a cycle timeout
 */

`timescale 1ns/1ps

`include "st_align_cfg.svh"

module tb_st_align;

  localparam int NUM_SEQ   = 200;
  localparam int RST_CYC   = 16;
  // up to 9 memory beats a sequence, 8 cycles each with stalls
  localparam int LIMIT_CYC = NUM_SEQ * 9 * 8 + RST_CYC;

  logic                     align_clk;
  logic                     cpurst_b;
  logic                     cfg_wr;
  st_align_pkg::st_desc_t   cfg_desc;
  logic                     flush;
  logic                     in_vld;
  st_align_pkg::reg_beat_t  in_beat;
  logic                     in_ack;
  logic                     mem_ready;
  logic                     mem_vld;
  st_align_pkg::mem_beat_t  mem_beat;

  integer seed;
  int     cyc_cnt = 0;
  string  test_name;

  // register beats and expected memory beats of one sequence
  logic [`ST_DATAW-1:0]    src_data [8];
  logic [7:0]              byte_q[$];
  st_align_pkg::mem_beat_t exp_q[$];

  // stalled beat of the previous cycle
  logic                    prev_stall;
  st_align_pkg::mem_beat_t prev_beat;
  logic                    seq_end;

  st_align_top st_align_top_inst (
    .align_clk (align_clk),
    .cpurst_b  (cpurst_b ),
    .cfg_wr    (cfg_wr   ),
    .cfg_desc  (cfg_desc ),
    .flush     (flush    ),
    .in_vld    (in_vld   ),
    .in_beat   (in_beat  ),
    .in_ack    (in_ack   ),
    .mem_ready (mem_ready),
    .mem_vld   (mem_vld  ),
    .mem_beat  (mem_beat )
  );

  always #20 align_clk = ~align_clk;

  always @(posedge align_clk)
  begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt > LIMIT_CYC)
    begin
      $display("timeout, the run did not finish within %0d cycles", LIMIT_CYC);
      report_fail();
    end
  end

  // ==============================
  // helpers
  // ==============================
  task automatic report_fail();
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_val(input string what, input logic [`ST_DATAW-1:0] exp_v,
                           input logic [`ST_DATAW-1:0] act_v);
    assert (exp_v === act_v)
    else
    begin
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp_v, act_v);
      report_fail();
    end
  endtask

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // inputs change just after the rising edge
  task automatic next_edge();
    @(posedge align_clk);
    #1;
  endtask

  // pairs 0..3 equal sizes, 4 byte/half, 5 byte/word, 6 half/word
  task automatic pick_pair(input int k, output st_align_pkg::size_e ms,
                           output st_align_pkg::size_e sw);
    if (k < 4)
    begin
      sw = st_align_pkg::size_e'(2'(k));
      ms = sw;
    end
    else
    begin
      sw = (k == 4) ? st_align_pkg::HALF : st_align_pkg::WORD;
      ms = (k == 6) ? st_align_pkg::HALF : st_align_pkg::BYTE;
    end
  endtask

  // ==============================
  // reference model
  // ==============================
  task automatic build_expected(input logic [2:0] rot, input st_align_pkg::size_e ms,
                                input st_align_pkg::size_e sw, input int nbeats);
    int                      es;
    int                      mw;
    int                      total;
    int                      nwin;
    int                      p;
    st_align_pkg::mem_beat_t bt;
    byte_q.delete();
    exp_q.delete();
    es = 1 << sw;
    mw = 1 << ms;
    // low mw bytes of each es-byte element, element order
    for (int b = 0; b < nbeats; b++)
    begin
      for (int e = 0; e < 8 / es; e++)
      begin
        for (int k = 0; k < mw; k++)
        begin
          byte_q.push_back(src_data[b][(e * es + k) * 8 +: 8]);
        end
      end
    end
    total = byte_q.size();
    // stream starts at lane rot, cut into 8-lane windows
    nwin  = (rot + total + 7) / 8;
    for (int w = 0; w < nwin; w++)
    begin
      bt = '0;
      for (int l = 0; l < 8; l++)
      begin
        p = w * 8 + l - rot;
        if (p >= 0 && p < total)
        begin
          bt.be[l]          = 1'b1;
          bt.data[l*8 +: 8] = byte_q[p];
        end
      end
      bt.last = (w == nwin - 1);
      exp_q.push_back(bt);
    end
  endtask

  // ==============================
  // per-cycle checker
  // ==============================
  // mid cycle, everything settled since the drive point
  task automatic sample_cycle(output logic took);
    logic [`ST_DATAW-1:0] dmask;
    @(negedge align_clk);
    if (prev_stall)
    begin
      check_val("backpressure mem_vld", 1, mem_vld);
      check_val("backpressure data", prev_beat.data, mem_beat.data);
      check_val("backpressure be", prev_beat.be, mem_beat.be);
      check_val("backpressure last", prev_beat.last, mem_beat.last);
    end
    if (mem_vld && !mem_ready)
      check_val("in_ack with stalled beat", 0, in_ack);
    if (mem_vld && mem_ready)
    begin
      assert (exp_q.size() > 0)
      else
      begin
        $display("%s: memory beat consumed when none was expected", test_name);
        report_fail();
      end
      // disabled lanes carry no data
      for (int l = 0; l < 8; l++)
      begin
        dmask[l*8 +: 8] = {8{exp_q[0].be[l]}};
      end
      check_val("be", exp_q[0].be, mem_beat.be);
      check_val("data", exp_q[0].data, mem_beat.data & dmask);
      check_val("last", exp_q[0].last, mem_beat.last);
      seq_end = mem_beat.last;
      void'(exp_q.pop_front());
    end
    prev_stall = mem_vld && !mem_ready;
    prev_beat  = mem_beat;
    took       = in_vld && in_ack;
  endtask

  // ==============================
  // one store sequence
  // ==============================
  task automatic run_sequence(input int idx);
    st_align_pkg::size_e ms;
    st_align_pkg::size_e sw;
    logic [2:0]          rot;
    int                  nbeats;
    int                  flush_at;
    int                  b;
    logic                took;
    logic                pending;
    // first five cover aligned, unaligned and each narrowing pair
    pick_pair((idx < 2) ? 3 : (idx < 5) ? idx + 2 : rand_below(7), ms, sw);
    rot      = (idx == 0) ? 3'd0 : (idx == 1) ? 3'd5 : 3'(rand_below(8));
    nbeats   = 1 + rand_below(8);
    flush_at = nbeats;
    if (idx >= 5 && idx % 8 == 6 && nbeats > 1)
      flush_at = 1 + rand_below(nbeats - 1);
    for (int i = 0; i < nbeats; i++)
    begin
      src_data[i] = {$random(seed), $random(seed)};
    end
    build_expected(rot, ms, sw, nbeats);
    if (flush_at < nbeats)
      test_name = "flush";
    else if (ms != sw)
      test_name = "narrow";
    else if (rot == 3'd0)
      test_name = "aligned";
    else
      test_name = "unaligned";

    cfg_desc = '{rot: rot, sew: sw, mem_size: ms};
    cfg_wr   = 1'b1;
    next_edge();
    cfg_wr     = 1'b0;
    b          = 0;
    pending    = 1'b0;
    seq_end    = 1'b0;
    prev_stall = 1'b0;
    while (!seq_end && !(b == flush_at && flush_at < nbeats))
    begin
      // random gap before each offer, held once offered
      if (!pending && b < nbeats)
        pending = (rand_below(4) != 0);
      in_vld = pending;
      if (b < nbeats)
      begin
        in_beat.data = src_data[b];
        in_beat.last = (b == nbeats - 1);
      end
      mem_ready = (rand_below(4) != 0);
      sample_cycle(took);
      if (took)
      begin
        b       = b + 1;
        pending = 1'b0;
      end
      next_edge();
    end
    in_vld = 1'b0;

    if (!seq_end)
    begin
      // held bytes dropped, nothing more of this sequence
      flush = 1'b1;
      @(negedge align_clk);
      check_val("mem_vld at flush", 0, mem_vld);
      next_edge();
      flush  = 1'b0;
      in_vld = 1'b1;
      repeat (3)
      begin
        @(negedge align_clk);
        check_val("mem_vld after flush", 0, mem_vld);
        check_val("in_ack after flush", 0, in_ack);
        next_edge();
      end
      in_vld = 1'b0;
    end
    else
    begin
      check_val("beats left over", 0, exp_q.size());
    end
    // active flag is down before the next strobe
    next_edge();
  endtask

  // ==============================
  // main flow
  // ==============================
  initial
  begin
    seed       = 32'h560d;
    test_name  = "reset";
    prev_stall = 1'b0;
    seq_end    = 1'b0;
    align_clk  = 1'b0;
    cpurst_b   = 1'b0;
    cfg_wr     = 1'b0;
    cfg_desc   = '0;
    flush      = 1'b0;
    in_vld     = 1'b0;
    in_beat    = '0;
    mem_ready  = 1'b0;
    repeat (RST_CYC) @(posedge align_clk);
    #1;
    cpurst_b = 1'b1;

    // input offered with no sequence configured
    in_vld    = 1'b1;
    mem_ready = 1'b1;
    in_beat   = '{data: 64'h0123_4567_89ab_cdef, last: 1'b1};
    repeat (4)
    begin
      @(negedge align_clk);
      check_val("mem_vld", 0, mem_vld);
      check_val("in_ack", 0, in_ack);
      next_edge();
    end
    in_vld = 1'b0;

    for (int i = 0; i < NUM_SEQ; i++)
    begin
      run_sequence(i);
    end

    // every failing check has already stopped the run
    $display("test passed");
    $finish;
  end

endmodule
